/* common/link_pkg.sv */
package link_pkg;

    // received packet types use 5..7 and F and sent types use 8..E
    typedef enum logic [3:0] {
        bag_init   = 4'h0,
        bag_didx   = 4'h5,
        bag_dparam = 4'h6,
        bag_ddidx  = 4'h7,
        bag_dlink  = 4'h8,
        bag_dtype  = 4'h9,
        bag_dtemp  = 4'hA,
        bag_data0  = 4'hD,
        bag_data1  = 4'hE,
        bag_error  = 4'hF
    } btype_t;

    // packet ram map
    localparam logic [11:0] ram_addr_idle   = 12'hFE0;
    localparam logic [11:0] ram_addr_dlink  = 12'hFCC;
    localparam logic [11:0] ram_addr_dtype  = 12'hFC0;
    localparam logic [11:0] ram_addr_dtemp  = 12'hFC4;
    localparam logic [11:0] ram_data_base   = 12'h000;
    localparam logic [11:0] ram_data_stride = 12'h240;

    // upper nibble of every valid command byte
    localparam logic [3:0] cmd_sync = 4'hA;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic        valid;
        logic        last;
        btype_t      btype;
        logic [15:0] data;
    } tx_word_t;

    // one ram word read either as a frame header or as an adc sample
    typedef union packed {
        struct packed {
            btype_t      btype;
            logic [11:0] seq;
        } hdr;
        struct packed {
            logic [3:0]  chan;
            logic [11:0] code;
        } smp;
    } ram_word_u;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        ram_word_u   data;
    } ram_wr_t;

    function automatic logic [11:0] data_base(input int unsigned blk);
        return ram_data_base + 12'(blk * ram_data_stride);
    endfunction

endpackage

/* common/adc_pkg.sv */
package adc_pkg;

    // strobed sample as delivered by the adc front end
    typedef struct packed {
        logic        valid;
        logic [3:0]  chan;
        logic [11:0] code;
    } adc_sample_t;

    // link frame marker
    localparam logic [15:0] link_magic = 16'h5AA5;

    // identity returned in the type frame
    localparam logic [15:0] device_id  = 16'h0A71;
    localparam logic [15:0] device_rev = 16'h0003;

    // fixed converter setup that opens the temperature frame
    localparam logic [15:0] adc_conf_word = 16'h8C10;

endpackage

/* hdl/packet_ram.sv */
`timescale 1ns/10ps

module packet_ram (
    input  logic                clk,
    input  link_pkg::ram_wr_t   wr,
    input  logic [11:0]         rd_addr,
    output link_pkg::ram_word_u rd_data
);

    localparam int depth = 1 << 12;

    link_pkg::ram_word_u mem [depth];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read returns old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/com_rx.sv */
`timescale 1ns/10ps

module com_rx (
    input  logic               clk,
    input  logic               rst,
    input  link_pkg::rx_byte_t rx,
    input  logic               fd_com_read,
    output logic               fs_com_read,
    output link_pkg::btype_t   read_btype
);

    logic             sync_ok;
    link_pkg::btype_t rx_btype;

    assign sync_ok = rx.valid && (rx.data[7:4] == link_pkg::cmd_sync);

    // only request types pass, anything else is reported as an error
    always_comb begin
        case (rx.data[3:0])
            link_pkg::bag_didx:   rx_btype = link_pkg::bag_didx;
            link_pkg::bag_dparam: rx_btype = link_pkg::bag_dparam;
            link_pkg::bag_ddidx:  rx_btype = link_pkg::bag_ddidx;
            default:              rx_btype = link_pkg::bag_error;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_com_read <= 1'b0;
            read_btype  <= link_pkg::bag_init;
        end else if (fs_com_read) begin
            // bytes are ignored until the console has taken the command
            if (fd_com_read) fs_com_read <= 1'b0;
        end else if (sync_ok) begin
            fs_com_read <= 1'b1;
            read_btype  <= rx_btype;
        end
    end

endmodule

/* hdl/com_tx.sv */
`timescale 1ns/10ps

module com_tx (
    input  logic                clk,
    input  logic                rst,
    input  logic                fs_com_send,
    input  link_pkg::btype_t    send_btype,
    input  logic [11:0]         ram_addr_init,
    input  logic [11:0]         ram_dlen,
    input  logic                tx_abort,
    input  link_pkg::ram_word_u rd_data,
    output logic [11:0]         rd_addr,
    output link_pkg::tx_word_t  tx,
    output logic                fd_com_send,
    output logic                fd_com_txer
);

    typedef enum logic [1:0] {tx_idle, tx_run, tx_done, tx_abrt} state_t;

    state_t      st;
    logic [11:0] rd_left;
    logic        vld_q;
    logic        last_q;
    logic        in_frame;

    assign in_frame = (st == tx_run) || vld_q;

    // valid trails the read address by the ram latency
    assign tx.valid    = vld_q && !tx_abort;
    assign tx.last     = last_q && !tx_abort;
    assign tx.btype    = send_btype;
    assign tx.data     = rd_data;
    assign fd_com_send = tx.valid && tx.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st          <= tx_idle;
            rd_addr     <= '0;
            rd_left     <= '0;
            vld_q       <= 1'b0;
            last_q      <= 1'b0;
            fd_com_txer <= 1'b0;
        end else begin
            vld_q       <= (st == tx_run);
            last_q      <= (st == tx_run) && (rd_left == 12'd1);
            fd_com_txer <= 1'b0;
            if (tx_abort && in_frame) begin
                // one idle cycle lets the console drop or keep the send level
                st          <= tx_abrt;
                vld_q       <= 1'b0;
                last_q      <= 1'b0;
                fd_com_txer <= 1'b1;
            end else begin
                case (st)
                    tx_idle: begin
                        if (fs_com_send) begin
                            rd_addr <= ram_addr_init;
                            rd_left <= ram_dlen;
                            st      <= tx_run;
                        end
                    end
                    tx_run: begin
                        if (rd_left == 12'd1) begin
                            st <= tx_done;
                        end else begin
                            rd_addr <= rd_addr + 12'd1;
                            rd_left <= rd_left - 12'd1;
                        end
                    end
                    tx_done: if (!fs_com_send) st <= tx_idle;
                    default: st <= tx_idle;
                endcase
            end
        end
    end

endmodule

/* hdl/adc_ctrl.sv */
`timescale 1ns/10ps

module adc_ctrl #(
    parameter int conv_len = 512,
    parameter int blk_num  = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs_adc_init,
    input  logic                 fs_adc_type,
    input  logic                 fs_adc_conf,
    input  logic                 fs_adc_conv,
    input  logic                 fs_adc_tran,
    input  adc_pkg::adc_sample_t adc_in,
    input  logic [11:0]          temp_code,
    output logic                 fd_adc_init,
    output logic                 fd_adc_type,
    output logic                 fd_adc_conf,
    output logic                 fd_adc_conv,
    output logic                 fd_adc_tran,
    output link_pkg::ram_wr_t    ram_wr
);

    localparam int blk_w = (blk_num > 1) ? $clog2(blk_num) : 1;
    localparam int cnt_w = $clog2(conv_len + 1);

    typedef enum logic [2:0] {
        st_idle, st_link2, st_type2, st_conf2, st_smp, st_len
    } state_t;

    state_t              st;
    logic [4:0]          fs_vec;
    logic [4:0]          fs_q;
    logic [4:0]          rise;
    logic [blk_w-1:0]    blk_idx;
    logic [11:0]         blk_base;
    logic [11:0]         seq;
    logic [cnt_w-1:0]    smp_cnt;
    link_pkg::ram_word_u hdr_word;
    link_pkg::ram_word_u smp_word;

    function automatic link_pkg::ram_wr_t wr_word(input logic [11:0] addr,
                                                  input link_pkg::ram_word_u data);
        link_pkg::ram_wr_t w;
        w.en   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // strobes are levels, each job starts on the rising edge
    assign fs_vec   = {fs_adc_tran, fs_adc_conv, fs_adc_conf, fs_adc_type, fs_adc_init};
    assign rise     = fs_vec & ~fs_q;
    assign blk_base = link_pkg::data_base(blk_idx);

    always_comb begin
        hdr_word.hdr.btype = blk_idx[0] ? link_pkg::bag_data1 : link_pkg::bag_data0;
        hdr_word.hdr.seq   = seq;
        smp_word.smp.chan  = adc_in.chan;
        smp_word.smp.code  = adc_in.code;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st          <= st_idle;
            fs_q        <= '0;
            ram_wr      <= '0;
            fd_adc_init <= 1'b0;
            fd_adc_type <= 1'b0;
            fd_adc_conf <= 1'b0;
            fd_adc_conv <= 1'b0;
            fd_adc_tran <= 1'b0;
            blk_idx     <= '0;
            seq         <= '0;
            smp_cnt     <= '0;
        end else begin
            fs_q        <= fs_vec;
            ram_wr.en   <= 1'b0;
            fd_adc_init <= 1'b0;
            fd_adc_type <= 1'b0;
            fd_adc_conf <= 1'b0;
            fd_adc_conv <= 1'b0;
            fd_adc_tran <= rise[4];
            // handover runs alongside the fsm while the block is sent
            if (rise[4]) begin
                blk_idx <= (blk_idx == blk_w'(blk_num - 1)) ? '0 : blk_idx + 1'b1;
            end
            case (st)
                st_idle: begin
                    if (rise[0]) begin
                        ram_wr <= wr_word(link_pkg::ram_addr_dlink, adc_pkg::link_magic);
                        st     <= st_link2;
                    end else if (rise[1]) begin
                        ram_wr <= wr_word(link_pkg::ram_addr_dtype, adc_pkg::device_id);
                        st     <= st_type2;
                    end else if (rise[2]) begin
                        ram_wr <= wr_word(link_pkg::ram_addr_dtemp, adc_pkg::adc_conf_word);
                        st     <= st_conf2;
                    end else if (rise[3]) begin
                        ram_wr  <= wr_word(blk_base, hdr_word);
                        seq     <= seq + 1'b1;
                        smp_cnt <= '0;
                        st      <= st_smp;
                    end
                end
                st_link2: begin
                    ram_wr      <= wr_word(link_pkg::ram_addr_dlink + 12'd1, adc_pkg::device_id);
                    fd_adc_init <= 1'b1;
                    st          <= st_idle;
                end
                st_type2: begin
                    ram_wr      <= wr_word(link_pkg::ram_addr_dtype + 12'd1, adc_pkg::device_rev);
                    fd_adc_type <= 1'b1;
                    st          <= st_idle;
                end
                st_conf2: begin
                    ram_wr      <= wr_word(link_pkg::ram_addr_dtemp + 12'd1, {4'h0, temp_code});
                    fd_adc_conf <= 1'b1;
                    st          <= st_idle;
                end
                st_smp: begin
                    // samples land after the two header words
                    if (adc_in.valid) begin
                        ram_wr  <= wr_word(blk_base + 12'd2 + 12'(smp_cnt), smp_word);
                        smp_cnt <= smp_cnt + 1'b1;
                        if (smp_cnt == cnt_w'(conv_len - 1)) st <= st_len;
                    end
                end
                st_len: begin
                    // length word goes in last so no sample slot is spent on it
                    ram_wr      <= wr_word(blk_base + 12'd1, 16'(conv_len));
                    fd_adc_conv <= 1'b1;
                    st          <= st_idle;
                end
                default: st <= st_idle;
            endcase
        end
    end

    // a sample that comes while a conversion is requested must hit the collect window
    a_no_lost_sample: assert property (@(posedge clk) disable iff (rst)
        fs_adc_conv && adc_in.valid |-> (st == st_smp));

endmodule

/* console/console.sv */
`timescale 1ns/10ps

module console #(
    parameter int conv_len = 512,
    parameter int blk_num  = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fd_adc_init,
    input  logic              fd_adc_type,
    input  logic              fd_adc_conf,
    input  logic              fd_adc_conv,
    input  logic              fd_adc_tran,
    input  logic              fd_com_send,
    input  logic              fd_com_txer,
    input  logic              fs_com_read,
    input  link_pkg::btype_t  read_btype,
    output logic              fs_adc_init,
    output logic              fs_adc_type,
    output logic              fs_adc_conf,
    output logic              fs_adc_conv,
    output logic              fs_adc_tran,
    output logic              fs_com_send,
    output logic              fd_com_read,
    output link_pkg::btype_t  send_btype,
    output logic [11:0]       ram_dlen,
    output logic [11:0]       ram_addr_init
);

    localparam int link_wait_cycles = 12;
    localparam int wait_w = $clog2(link_wait_cycles);
    localparam int blk_w = (blk_num > 1) ? $clog2(blk_num) : 1;

    typedef enum logic [4:0] {
        st_reset, link_work, link_wait, link_take, link_send,
        main_wait, main_take,
        type_ack, type_work, type_take, type_send,
        conf_ack, conf_work, conf_take, conf_send,
        conv_ack, conv_work, conv_take, conv_send,
        err_ack
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [wait_w-1:0] wait_cnt;
    logic [blk_w-1:0] blk_idx;
    logic             tran_seen;
    logic             send_seen;
    logic             tran_ok;
    logic             send_ok;

    assign fs_adc_init = (state == link_work);
    assign fs_adc_type = (state == type_work);
    assign fs_adc_conf = (state == conf_work);
    assign fs_adc_conv = (state == conv_work);
    assign fs_adc_tran = (state == conv_send);
    assign fs_com_send = state inside {link_send, type_send, conf_send, conv_send};
    assign fd_com_read = state inside {type_ack, conf_ack, conv_ack, err_ack};

    // a data frame ends once both the ram handover and the send are done
    assign tran_ok = fd_adc_tran || tran_seen;
    assign send_ok = fd_com_send || send_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset:  next_state = link_work;
            link_work: if (fd_adc_init) next_state = link_wait;
            link_wait: if (wait_cnt == wait_w'(link_wait_cycles - 1)) next_state = link_take;
            link_take: next_state = link_send;
            link_send: begin
                // an aborted link frame is sent again after a fresh wait
                if (fd_com_send) next_state = main_wait;
                else if (fd_com_txer) next_state = link_wait;
            end
            main_wait: if (fs_com_read) next_state = main_take;
            main_take: begin
                case (read_btype)
                    link_pkg::bag_didx:   next_state = type_ack;
                    link_pkg::bag_dparam: next_state = conf_ack;
                    link_pkg::bag_ddidx:  next_state = conv_ack;
                    default:              next_state = err_ack;
                endcase
            end
            type_ack:  if (!fs_com_read) next_state = type_work;
            type_work: if (fd_adc_type) next_state = type_take;
            type_take: next_state = type_send;
            type_send: if (fd_com_send) next_state = main_wait;
            conf_ack:  if (!fs_com_read) next_state = conf_work;
            conf_work: if (fd_adc_conf) next_state = conf_take;
            conf_take: next_state = conf_send;
            conf_send: if (fd_com_send) next_state = main_wait;
            conv_ack:  if (!fs_com_read) next_state = conv_work;
            conv_work: if (fd_adc_conv) next_state = conv_take;
            conv_take: next_state = conv_send;
            conv_send: if (tran_ok && send_ok) next_state = main_wait;
            err_ack:   if (!fs_com_read) next_state = main_wait;
            default:   next_state = st_reset;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt  <= '0;
            blk_idx   <= '0;
            tran_seen <= 1'b0;
            send_seen <= 1'b0;
        end else begin
            if (state == link_wait) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
            if (state == conv_take) begin
                blk_idx <= (blk_idx == blk_w'(blk_num - 1)) ? '0 : blk_idx + 1'b1;
            end
            tran_seen <= (state == conv_send) && tran_ok;
            send_seen <= (state == conv_send) && send_ok;
        end
    end

    // frame descriptor is loaded in the take states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_btype    <= link_pkg::bag_init;
            ram_addr_init <= link_pkg::ram_addr_idle;
            ram_dlen      <= '0;
        end else begin
            case (state)
                main_wait: begin
                    send_btype    <= link_pkg::bag_init;
                    ram_addr_init <= link_pkg::ram_addr_idle;
                    ram_dlen      <= '0;
                end
                link_take: begin
                    send_btype    <= link_pkg::bag_dlink;
                    ram_addr_init <= link_pkg::ram_addr_dlink;
                    ram_dlen      <= 12'd2;
                end
                type_take: begin
                    send_btype    <= link_pkg::bag_dtype;
                    ram_addr_init <= link_pkg::ram_addr_dtype;
                    ram_dlen      <= 12'd2;
                end
                conf_take: begin
                    send_btype    <= link_pkg::bag_dtemp;
                    ram_addr_init <= link_pkg::ram_addr_dtemp;
                    ram_dlen      <= 12'd2;
                end
                conv_take: begin
                    // odd blocks go out as DATA1
                    send_btype    <= blk_idx[0] ? link_pkg::bag_data1 : link_pkg::bag_data0;
                    ram_addr_init <= link_pkg::data_base(blk_idx);
                    ram_dlen      <= 12'(conv_len + 2);
                end
                default: begin
                end
            endcase
        end
    end

    a_send_excl: assert property (@(posedge clk) disable iff (rst)
        fs_com_send |-> !(fs_adc_init || fs_adc_type || fs_adc_conf || fs_adc_conv));

    // the length seen by com_tx stays put for the whole send
    a_send_len: assert property (@(posedge clk) disable iff (rst)
        fs_com_send |-> (ram_dlen != 12'd0) && (!$past(fs_com_send) || $stable(ram_dlen)));

endmodule

/* hdl/adc_link_top.sv */
`timescale 1ns/10ps

module adc_link_top #(
    parameter int conv_len = 512,
    parameter int blk_num  = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  link_pkg::rx_byte_t   rx,
    input  adc_pkg::adc_sample_t adc_in,
    input  logic [11:0]          temp_code,
    input  logic                 tx_abort,
    output link_pkg::tx_word_t   tx
);

    logic fs_adc_init, fs_adc_type, fs_adc_conf, fs_adc_conv, fs_adc_tran;
    logic fd_adc_init, fd_adc_type, fd_adc_conf, fd_adc_conv, fd_adc_tran;
    logic fs_com_send, fd_com_send, fd_com_txer;
    logic fs_com_read, fd_com_read;

    link_pkg::btype_t    read_btype;
    link_pkg::btype_t    send_btype;
    logic [11:0]         ram_dlen;
    logic [11:0]         ram_addr_init;
    logic [11:0]         rd_addr;
    link_pkg::ram_word_u rd_data;
    link_pkg::ram_wr_t   ram_wr;

    console #(.conv_len(conv_len), .blk_num(blk_num)) console_i (
        .clk, .rst,
        .fd_adc_init, .fd_adc_type, .fd_adc_conf, .fd_adc_conv, .fd_adc_tran,
        .fd_com_send, .fd_com_txer, .fs_com_read, .read_btype,
        .fs_adc_init, .fs_adc_type, .fs_adc_conf, .fs_adc_conv, .fs_adc_tran,
        .fs_com_send, .fd_com_read, .send_btype, .ram_dlen, .ram_addr_init
    );

    adc_ctrl #(.conv_len(conv_len), .blk_num(blk_num)) adc_ctrl_i (
        .clk, .rst,
        .fs_adc_init, .fs_adc_type, .fs_adc_conf, .fs_adc_conv, .fs_adc_tran,
        .adc_in, .temp_code,
        .fd_adc_init, .fd_adc_type, .fd_adc_conf, .fd_adc_conv, .fd_adc_tran,
        .ram_wr
    );

    packet_ram packet_ram_i (
        .clk,
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    com_tx com_tx_i (
        .clk, .rst,
        .fs_com_send, .send_btype, .ram_addr_init, .ram_dlen, .tx_abort, .rd_data,
        .rd_addr, .tx, .fd_com_send, .fd_com_txer
    );

    com_rx com_rx_i (
        .clk, .rst,
        .rx, .fd_com_read, .fs_com_read, .read_btype
    );

endmodule

/* testbench/tb_adc_link_top.sv */
`timescale 1ns/10ps

module tb_adc_link_top;

    localparam int conv_len      = 4;
    localparam int frame_timeout = 200;

    logic                 clk;
    logic                 rst;
    link_pkg::rx_byte_t   rx;
    adc_pkg::adc_sample_t adc_in;
    logic [11:0]          temp_code;
    logic                 tx_abort;
    link_pkg::tx_word_t   tx;

    // inputs staged for the next falling edge
    logic                 rst_next;
    link_pkg::rx_byte_t   rx_next;
    adc_pkg::adc_sample_t adc_next;
    logic [11:0]          temp_next;
    logic                 abort_next;

    link_pkg::tx_word_t   tx_seen;
    link_pkg::tx_word_t   frame_q[$];
    adc_pkg::adc_sample_t sample_q[$];
    logic                 collecting;
    logic                 timed_out;
    int                   abort_after;
    int                   frame_no;
    int                   checks;
    int                   errors;
    int                   fd;

    adc_link_top #(.conv_len(conv_len)) adc_link_top_i (
        .clk, .rst, .rx, .adc_in, .temp_code, .tx_abort, .tx
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // staged inputs go out on the falling edge and tx is sampled just after
    task automatic next_cycle();
        @(negedge clk);
        rst        = rst_next;
        rx         = rx_next;
        adc_in     = adc_next;
        temp_code  = temp_next;
        tx_abort   = abort_next;
        rx_next    = '0;
        adc_next   = '0;
        abort_next = 1'b0;
        #1;
        tx_seen = tx;
        if (tx_seen.valid && !collecting) begin
            errors++;
            $display("tx sent word %h of type %h while no frame was expected",
                     tx_seen.data, tx_seen.btype);
        end
    endtask

    task automatic apply_reset();
        rst_next = 1'b1;
        repeat (10) next_cycle();
        rst_next = 1'b0;
        next_cycle();
    endtask

    task automatic check_word(input string name, input link_pkg::ram_word_u exp,
                              input link_pkg::ram_word_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_btype(input string name, input link_pkg::btype_t exp,
                               input link_pkg::btype_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // collect words up to the last flag, with one optional abort along the way
    task automatic receive_frame();
        int waited;
        bit done;
        bit abort_now;
        waited = 0;
        done = 1'b0;
        frame_q.delete();
        collecting = 1'b1;
        while (!done && waited < frame_timeout) begin
            abort_now = (abort_after > 0) && (frame_q.size() == abort_after);
            if (abort_now) begin
                abort_next  = 1'b1;
                abort_after = 0;
            end
            next_cycle();
            waited++;
            if (abort_now) begin
                if (tx_seen.valid) begin
                    errors++;
                    $display("tx sent a word in the abort cycle of frame %0d", frame_no);
                end
                // the frame starts over from its first word
                frame_q.delete();
            end else if (tx_seen.valid) begin
                frame_q.push_back(tx_seen);
                done = tx_seen.last;
            end
        end
        collecting = 1'b0;
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("frame %0d did not complete within %0d cycles", frame_no, frame_timeout);
        end
    endtask

    task automatic compare_frame();
        int                  bt_val;
        int                  len;
        int                  word_val;
        int                  code;
        string               name;
        link_pkg::btype_t    exp_bt;
        link_pkg::ram_word_u exp_q[$];
        link_pkg::ram_word_u exp_w;
        link_pkg::ram_word_u hdr_w;
        code = $fscanf(fd, "%h %d", bt_val, len);
        exp_bt = link_pkg::btype_t'(bt_val[3:0]);
        for (int i = 0; i < len; i++) begin
            code = $fscanf(fd, "%h", word_val);
            exp_w = word_val[15:0];
            exp_q.push_back(exp_w);
        end
        name = $sformatf("frame %0d", frame_no);
        receive_frame();
        if (!timed_out) begin
            check_len({name, " length"}, len, frame_q.size());
            foreach (frame_q[i]) begin
                check_btype($sformatf("%s word %0d type", name, i), exp_bt, frame_q[i].btype);
                if (i < len) begin
                    check_word($sformatf("%s word %0d", name, i), exp_q[i], frame_q[i].data);
                end
            end
            if (exp_bt == link_pkg::bag_data0 || exp_bt == link_pkg::bag_data1) begin
                // header view carries the frame type, sample view the driven inputs
                hdr_w = frame_q[0].data;
                check_btype({name, " header type"}, exp_bt, hdr_w.hdr.btype);
                check_len({name, " samples driven"}, conv_len, sample_q.size());
                foreach (sample_q[i]) begin
                    exp_w.smp.chan = sample_q[i].chan;
                    exp_w.smp.code = sample_q[i].code;
                    if (i + 2 < frame_q.size()) begin
                        check_word($sformatf("%s sample %0d", name, i), exp_w,
                                   frame_q[i + 2].data);
                    end
                end
            end
        end
        sample_q.delete();
        frame_no++;
    endtask

    initial begin
        logic [8*16-1:0]  tag;
        logic [8*128-1:0] line;
        int               code;
        int               val;
        int               chan;
        rst         = 1'b1;
        rx          = '0;
        adc_in      = '0;
        temp_code   = '0;
        tx_abort    = 1'b0;
        rst_next    = 1'b1;
        rx_next     = '0;
        adc_next    = '0;
        temp_next   = '0;
        abort_next  = 1'b0;
        collecting  = 1'b0;
        timed_out   = 1'b0;
        abort_after = 0;
        frame_no    = 0;
        checks      = 0;
        errors      = 0;
        fd = $fopen("testbench/golden_frames.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open testbench/golden_frames.txt");
        end else begin
            apply_reset();
            while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "R") begin
                    apply_reset();
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%d", val);
                    repeat (val) next_cycle();
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%h", val);
                    temp_next = val[11:0];
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%h", val);
                    rx_next = {1'b1, val[7:0]};
                    next_cycle();
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%h %h", chan, val);
                    adc_next = {1'b1, chan[3:0], val[11:0]};
                    sample_q.push_back(adc_next);
                    next_cycle();
                end else if (tag == "A") begin
                    code = $fscanf(fd, "%d", abort_after);
                end else if (tag == "F") begin
                    compare_frame();
                end else begin
                    errors++;
                    $display("golden file holds an unknown record kind %0s", tag);
                end
            end
            $fclose(fd);
        end
        $display("frames %0d, checks %0d, errors %0d", frame_no, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* testbench/golden_frames.txt */
# records: R reset | I idle_cycles | T temp_hex | C cmd_byte_hex | S chan_hex code_hex
# A words_before_abort | F btype_hex length word_hex ... (counts in decimal)
# link frame right after reset
F 8 2 5AA5 0A71
T 5C3
C A5
F 9 2 0A71 0003
C A6
F A 2 8C10 05C3
# seven data blocks, the last one reuses region 0
C A7 I 8 S 0 123 S 1 456 S 2 789 S 3 ABC
F D 6 D000 0004 0123 1456 2789 3ABC
C A7 I 8 S 4 001 S 5 FFF S 6 800 S 7 7FF
F E 6 E001 0004 4001 5FFF 6800 77FF
C A7 I 8 S 8 111 S 9 222 S A 333 S B 444
F D 6 D002 0004 8111 9222 A333 B444
C A7 I 8 S C 0F0 S D F0F S E 5A5 S F A5A
F E 6 E003 0004 C0F0 DF0F E5A5 FA5A
C A7 I 8 S 0 FFF S 0 000 S 1 FFF S 1 000
F D 6 D004 0004 0FFF 0000 1FFF 1000
C A7 I 8 S 3 3C3 S 2 C3C S 1 246 S 0 9BD
F E 6 E005 0004 33C3 2C3C 1246 09BD
C A7 I 8 S 7 DEA S 6 D0C S 5 0DE S 4 ACE
F D 6 D006 0004 7DEA 6D0C 50DE 4ACE
# no sync nibble, unknown type, error type
C 57 I 20
C A3 I 20
C AF I 20
C A5
F 9 2 0A71 0003
T 0FF
C A6
F A 2 8C10 00FF
# abort inside a type frame, then inside the link frame after a new reset
A 1 C A5
F 9 2 0A71 0003
R A 1
F 8 2 5AA5 0A71

/* adc_link_top.f */
common/link_pkg.sv
common/adc_pkg.sv
hdl/packet_ram.sv
hdl/com_rx.sv
hdl/com_tx.sv
hdl/adc_ctrl.sv
console/console.sv
hdl/adc_link_top.sv
testbench/tb_adc_link_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adc_link_top -f adc_link_top.f -o tb_adc_link_top
./obj_dir/tb_adc_link_top | tee sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
